/* src/game_pkg.sv */
package game_pkg;

	// screen and sprite geometry in pixels
	localparam int SCREEN_WIDTH = 640;
	localparam int BIRD_SIZE = 32;   // square sprite side
	localparam int Y_POS = 185;      // bird row, y never changes

	// position math keeps 6 fraction bits (1/64 pixel)
	localparam int FIXED_SHIFT = 6;

	// signed pixel coordinate, room for off-screen values
	typedef logic signed [10:0] coord_t;

	// x position in 1/64 pixel units
	typedef logic signed [16:0] fixed_t;

	typedef logic [3:0] life_t;      // remaining lives
	typedef logic [1:0] speed_t;     // 0 slowest .. 3 fastest
	typedef logic [7:0] rand_t;      // one pseudo random byte

	// bird life cycle
	// IDLE      not on screen, waits for a deploy
	// ACK_WAIT  deploy loaded, ack high until req drops
	// ACTIVE    flying and hittable
	// FLASH     last life gone, visible for one more frame
	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		FLASH,
		ACK_WAIT
	} motion_state_t;

endpackage

/* src/bird_if.sv */
`timescale 1ns/10ps

interface bird_if;

	import game_pkg::*;

	coord_t bird_x;       // top left corner
	coord_t bird_y;
	logic alive;          // bird visible and hittable
	logic hit_pending;    // a shot landed, not applied yet
	logic hit_taken;      // pulse, hit applied this frame

	// motion block owns position and life
	modport motion (
		output bird_x, bird_y, alive, hit_taken,
		input hit_pending
	);

	// hit detector only raises and clears the pending flag
	modport detect (
		input bird_x, bird_y, alive, hit_taken,
		output hit_pending
	);

endinterface

/* src/lfsr_random.sv */
`timescale 1ns/10ps

module lfsr_random #(
	parameter game_pkg::rand_t LFSR_SEED = 8'd29
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,           // step once per frame
	output game_pkg::rand_t random
);

	logic feedback;

	// taps 8,6,5,4 give the maximal 255-state sequence
	assign feedback = random[7] ^ random[5] ^ random[4] ^ random[3];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			random <= LFSR_SEED;
		end
		else if (random == '0) begin
			random <= LFSR_SEED;               // all zero state would stick, reload seed
		end
		else if (start_of_frame) begin
			random <= {random[6:0], feedback}; // shift left, new bit in lsb
		end
	end

endmodule

/* src/bird_motion.sv */
`timescale 1ns/10ps

module bird_motion #(
	parameter int INITIAL_X = 280,                          // start column in pixels
	parameter game_pkg::rand_t RIGHT_INDICATOR = 8'd155,    // random above this moves right
	parameter game_pkg::rand_t LEFT_INDICATOR = 8'd100      // random below this moves left
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,          // 30 Hz pulse
	input logic deploy_req,              // four phase request
	output logic deploy_ack,
	input game_pkg::life_t starting_life,
	input game_pkg::speed_t speed,
	input game_pkg::rand_t random,       // sampled on the frame pulse
	bird_if.motion bird
);

	import game_pkg::*;

	// start and right limit in fixed point
	localparam fixed_t START_POS = fixed_t'(INITIAL_X << FIXED_SHIFT);
	localparam fixed_t RIGHT_LIMIT = fixed_t'((SCREEN_WIDTH - 1 - BIRD_SIZE) << FIXED_SHIFT);

	motion_state_t state;
	fixed_t pos;          // top left x, 1/64 pixel units
	fixed_t pos_next;
	fixed_t step;
	life_t life;
	logic [2:0] speed_inc;
	logic moving;         // states where the bird flies
	logic take_hit;

	assign speed_inc = {1'b0, speed} + 3'd1;
	assign step = fixed_t'({speed_inc, 5'b0});   // (speed+1)*32, half a pixel per speed unit

	assign moving = (state == ACTIVE) || (state == FLASH);
	// a pending hit is consumed on the frame pulse, in FLASH it is just discarded
	assign take_hit = start_of_frame && moving && bird.hit_pending;

	// candidate position for this frame
	always_comb begin
		pos_next = pos;
		if ((random > RIGHT_INDICATOR) && (pos < RIGHT_LIMIT)) begin
			pos_next = pos + step;
		end
		else if ((random < LEFT_INDICATOR) && (pos > fixed_t'(0))) begin
			// never step past the left edge
			pos_next = (pos > step) ? pos - step : '0;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= IDLE;
			pos <= START_POS;
			life <= '0;
		end
		else begin
			case (state)
				IDLE: begin
					if (deploy_req) begin          // arm the bird, raise ack
						state <= ACK_WAIT;
						pos <= START_POS;
						life <= starting_life;
					end
				end
				ACK_WAIT: begin
					if (!deploy_req) begin         // requester released, drop ack
						// a deploy with no lives never shows up
						state <= (life == '0) ? IDLE : ACTIVE;
					end
				end
				ACTIVE: begin
					if (start_of_frame) begin
						pos <= pos_next;
						if (take_hit) begin
							if (life <= life_t'(1)) begin
								life <= '0;
								state <= FLASH;    // last life, flash for one frame
							end
							else begin
								life <= life - life_t'(1);
							end
						end
					end
				end
				FLASH: begin
					if (start_of_frame) begin
						pos <= pos_next;
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign deploy_ack = (state == ACK_WAIT);
	assign bird.alive = moving;
	assign bird.hit_taken = take_hit;
	assign bird.bird_x = coord_t'(pos >>> FIXED_SHIFT);   // drop fraction bits
	assign bird.bird_y = coord_t'(Y_POS);                 // row is fixed

endmodule

/* src/shot_hit_detect.sv */
`timescale 1ns/10ps

module shot_hit_detect (
	input logic clk,
	input logic resetN,
	input logic shot_valid,          // one cycle pulse with the coordinates
	input game_pkg::coord_t shot_x,
	input game_pkg::coord_t shot_y,
	bird_if.detect bird
);

	import game_pkg::*;

	coord_t x_max;      // right column of the box
	coord_t y_max;      // bottom row of the box
	logic in_box;
	logic hit;

	assign x_max = bird.bird_x + coord_t'(BIRD_SIZE - 1);
	assign y_max = bird.bird_y + coord_t'(BIRD_SIZE - 1);

	// signed compares, bird may sit at column 0
	always_comb begin
		in_box = (shot_x >= bird.bird_x) && (shot_x <= x_max) &&
			(shot_y >= bird.bird_y) && (shot_y <= y_max);
	end

	// second shot in the same frame is dropped, one life per frame at most
	assign hit = shot_valid && bird.alive && !bird.hit_pending && in_box;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bird.hit_pending <= 1'b0;
		end
		else if (bird.hit_taken) begin
			bird.hit_pending <= 1'b0;     // motion applied it this frame
		end
		else if (hit) begin
			bird.hit_pending <= 1'b1;
		end
	end

endmodule

/* src/bird_game_top.sv */
`timescale 1ns/10ps

module bird_game_top #(
	parameter int INITIAL_X = 280,
	parameter game_pkg::rand_t RIGHT_INDICATOR = 8'd155,
	parameter game_pkg::rand_t LEFT_INDICATOR = 8'd100,
	parameter game_pkg::rand_t LFSR_SEED = 8'd29
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,          // 30 Hz frame pulse
	input logic deploy_req,
	input logic shot_valid,
	input game_pkg::life_t starting_life,
	input game_pkg::speed_t speed,
	input game_pkg::coord_t shot_x,
	input game_pkg::coord_t shot_y,
	output logic deploy_ack,
	output logic alive,
	output logic hit_pending,
	output game_pkg::coord_t bird_x,
	output game_pkg::coord_t bird_y
);

	import game_pkg::*;

	rand_t random_byte;   // direction byte, new value each frame

	bird_if bird_bus ();

	lfsr_random #(
		.LFSR_SEED(LFSR_SEED)
	) lfsr_random_inst (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.random(random_byte)
	);

	bird_motion #(
		.INITIAL_X(INITIAL_X),
		.RIGHT_INDICATOR(RIGHT_INDICATOR),
		.LEFT_INDICATOR(LEFT_INDICATOR)
	) bird_motion_inst (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.deploy_req(deploy_req),
		.deploy_ack(deploy_ack),
		.starting_life(starting_life),
		.speed(speed),
		.random(random_byte),
		.bird(bird_bus.motion)
	);

	shot_hit_detect shot_hit_detect_inst (
		.clk(clk),
		.resetN(resetN),
		.shot_valid(shot_valid),
		.shot_x(shot_x),
		.shot_y(shot_y),
		.bird(bird_bus.detect)
	);

	// bus signals out to plain ports
	assign alive = bird_bus.alive;
	assign hit_pending = bird_bus.hit_pending;
	assign bird_x = bird_bus.bird_x;
	assign bird_y = bird_bus.bird_y;

endmodule

/* verification/bird_game_tb.sv */
`timescale 1ns/10ps

module bird_game_tb;

	import game_pkg::*;

	localparam int TIMEOUT = 50;    // cycles allowed per handshake phase
	localparam int BIRD_ROW = 185;  // y never changes

	logic clk;
	logic resetN;
	logic start_of_frame;
	logic deploy_req;
	logic shot_valid;
	life_t starting_life;
	speed_t speed;
	coord_t shot_x;
	coord_t shot_y;
	logic deploy_ack;
	logic alive;
	logic hit_pending;
	coord_t bird_x;
	coord_t bird_y;

	int errors;          // all failed checks
	int tests;           // records run
	int failed;          // records with at least one failure
	logic test_ok;

	bird_game_top bird_game_top_inst (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.deploy_req(deploy_req),
		.shot_valid(shot_valid),
		.starting_life(starting_life),
		.speed(speed),
		.shot_x(shot_x),
		.shot_y(shot_y),
		.deploy_ack(deploy_ack),
		.alive(alive),
		.hit_pending(hit_pending),
		.bird_x(bird_x),
		.bird_y(bird_y)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	task automatic check_value(input string name, input int actual, input int expected);
		assert (actual == expected) else begin
			$display("ERROR %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	// poll deploy_ack once per cycle until it reaches level
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while ((deploy_ack !== level) && (cycles < TIMEOUT)) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		assert (deploy_ack === level) else begin
			$display("timeout: deploy_ack did not go to %0b within %0d cycles", level, TIMEOUT);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	// four phase deploy, req held until ack is seen
	task automatic deploy_bird(input int life);
		@(posedge clk);
		#1;
		starting_life = life_t'(life);
		deploy_req = 1'b1;
		wait_ack(1'b1);
		deploy_req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic run_frames(input int count, input int spd);
		speed = speed_t'(spd);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			start_of_frame = 1'b1;    // one cycle pulse
			@(posedge clk);
			#1;
			start_of_frame = 1'b0;
		end
	endtask

	task automatic fire_shot(input int x, input int y);
		@(posedge clk);
		#1;
		shot_x = coord_t'(x);
		shot_y = coord_t'(y);
		shot_valid = 1'b1;
		@(posedge clk);
		#1;
		shot_valid = 1'b0;            // hit_pending registered at that edge
	endtask

	initial begin
		int fd;
		int n;
		int count;
		int a;
		int b;
		int c;
		int exp_x;
		int exp_alive;
		int exp_hp;
		string line;
		string op;
		errors = 0;
		tests = 0;
		failed = 0;
		test_ok = 1'b1;
		resetN = 1'b0;
		start_of_frame = 1'b0;
		deploy_req = 1'b0;
		shot_valid = 1'b0;
		starting_life = '0;
		speed = '0;
		shot_x = '0;
		shot_y = '0;
		repeat (3) @(posedge clk);
		#1;
		resetN = 1'b1;
		fd = $fopen("verification/bird_game_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/bird_game_input.txt");
			errors++;
		end
		else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if ((n == 0) || (line.len() < 2) || (line.substr(0, 0) == "#")) begin
					continue;                 // blank or comment line
				end
				count = $sscanf(line, "%s %d %d %d %d %d %d", op, a, b, c,
					exp_x, exp_alive, exp_hp);
				if (count != 7) begin
					$display("record could not be parsed: %s", line);
					errors++;
					continue;
				end
				tests++;
				test_ok = 1'b1;
				if (op == "CHECK") begin
					check_value("deploy_ack", 32'(deploy_ack), 0);
					check_value("bird_y", 32'(bird_y), BIRD_ROW);
				end
				else if (op == "DEPLOY") begin
					deploy_bird(a);
				end
				else if (op == "FRAME") begin
					run_frames(a, b);
				end
				else if (op == "SHOT") begin
					fire_shot(a, b);
				end
				else begin
					$display("unknown opcode %s in record %0d", op, tests);
					errors++;
					test_ok = 1'b0;
				end
				check_value("bird_x", 32'(bird_x), exp_x);
				check_value("alive", 32'(alive), exp_alive);
				check_value("hit_pending", 32'(hit_pending), exp_hp);
				if (!test_ok) begin
					failed++;
				end
				$display("test %0d %s: %s", tests, op, test_ok ? "ok" : "FAILED");
			end
			$fclose(fd);
		end
		if (tests == 0) begin
			$display("no records were run");
			errors++;
		end
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end
		else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* verification/bird_game_input.txt */
# op a b c exp_x exp_alive exp_hp
# DEPLOY a=life, FRAME a=frames b=speed, SHOT a=shot_x b=shot_y, c unused
CHECK 0 0 0 280 0 0
DEPLOY 3 0 0 280 1 0
# speed 0, random values 29 .. 80
FRAME 10 0 0 280 1 0
FRAME 10 0 0 281 1 0
# speed 1, random values 161 .. 23
FRAME 10 1 0 277 1 0
FRAME 10 1 0 282 1 0
# speed 2, random values 47 .. 17
FRAME 10 2 0 282 1 0
FRAME 10 2 0 276 1 0
# speed 3, random values 35 .. 129
FRAME 10 3 0 270 1 0
FRAME 10 3 0 268 1 0
# box is 268..299 by 185..216
SHOT 300 190 0 268 1 0
SHOT 268 184 0 268 1 0
SHOT 268 185 0 268 1 1
SHOT 299 216 0 268 1 1
FRAME 1 3 0 266 1 0
SHOT 280 200 0 266 1 1
FRAME 1 3 0 264 1 0
SHOT 264 216 0 264 1 1
# last life, flash frame then gone
FRAME 1 3 0 262 1 0
FRAME 1 3 0 260 0 0
SHOT 270 200 0 260 0 0
FRAME 1 3 0 260 0 0
# redeploy, random 100 holds still
DEPLOY 2 0 0 280 1 0
FRAME 1 0 0 280 1 0

/* vlog.f */
src/game_pkg.sv
src/bird_if.sv
src/lfsr_random.sv
src/bird_motion.sv
src/shot_hit_detect.sv
src/bird_game_top.sv
verification/bird_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the bird game testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module bird_game_tb \
	-o bird_game_sim

./obj_dir/bird_game_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "^Done: no errors$" "$LOG"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
